/* dma_pkg.sv */
package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////////////////////

  // Bus address and data words
  localparam int BUS_WIDTH = 32;
  // Transfer length in words
  localparam int DMA_SIZE_WIDTH = 16;
  // Remote tile identifier
  localparam int DMA_TILE_WIDTH = 16;

  // Descriptor fields held by one table entry
  localparam int DMA_FIELDS = 5;

  // Each entry owns a 32-byte window in the bus address space
  localparam int ENTRY_STRIDE_LOG2 = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Register offsets inside an entry window
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [4:0] REG_LADDR  = 5'h00;
  localparam logic [4:0] REG_SIZE   = 5'h04;
  localparam logic [4:0] REG_RTILE  = 5'h08;
  localparam logic [4:0] REG_RADDR  = 5'h0C;
  localparam logic [4:0] REG_DIR    = 5'h10;
  // Write sets valid, read returns done and frees a finished entry
  localparam logic [4:0] REG_STATUS = 5'h14;

  // Bit positions in the one-hot field select
  localparam int FIELD_LADDR = 0;
  localparam int FIELD_SIZE  = 1;
  localparam int FIELD_RTILE = 2;
  localparam int FIELD_RADDR = 3;
  localparam int FIELD_DIR   = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [BUS_WIDTH-1:0]      bus_addr_t;
  typedef logic [BUS_WIDTH-1:0]      bus_data_t;
  typedef logic [DMA_SIZE_WIDTH-1:0] dma_size_t;
  typedef logic [DMA_TILE_WIDTH-1:0] dma_tile_t;
  typedef logic [DMA_FIELDS-1:0]     dma_select_t;

  // Scheduler FSM
  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_ISSUE,
    SCHED_WAIT
  } sched_state_t;

endpackage

/* dma_table_if.sv */
`timescale 1ns/1ps

interface dma_table_if import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4
) ();

  // Entry pointer width
  localparam int PTR_W = $clog2(TABLE_ENTRIES);

  // Descriptor field write, one field per cycle
  logic             wr_en;
  logic [PTR_W-1:0] wr_pos;
  dma_select_t      wr_select;
  bus_data_t        wr_data;

  // Status command
  // valid_set high sets valid, low clears valid and done
  logic             valid_en;
  logic             valid_set;
  logic [PTR_W-1:0] valid_pos;

  // Bus side drives, every entry listens
  modport bus (
    output wr_en,
    output wr_pos,
    output wr_select,
    output wr_data,
    output valid_en,
    output valid_set,
    output valid_pos
  );

  // Entries match the position against their own index
  modport entry (
    input wr_en,
    input wr_pos,
    input wr_select,
    input wr_data,
    input valid_en,
    input valid_set,
    input valid_pos
  );

endinterface

/* dma_entry_if.sv */
`timescale 1ns/1ps

interface dma_entry_if import dma_pkg::*; ();

  // Valid and not yet done
  logic      pending;

  // Descriptor contents
  bus_addr_t laddr;
  dma_size_t size;
  dma_tile_t rtile;
  bus_addr_t raddr;
  logic      dir;

  // One-cycle pulse from the scheduler when the network reports completion
  logic      complete;

  modport entry (
    output pending,
    output laddr,
    output size,
    output rtile,
    output raddr,
    output dir,
    input  complete
  );

  modport sched (
    input  pending,
    input  laddr,
    input  size,
    input  rtile,
    input  raddr,
    input  dir,
    output complete
  );

endinterface

/* dma_bus_interface.sv */
`timescale 1ns/1ps

module dma_bus_interface import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                     hsel,
  input  bus_addr_t                haddr,
  input  bus_data_t                hwdata,
  input  logic                     hwrite,
  input  logic                     hmastlock,
  output bus_data_t                hrdata,
  output logic                     hready,
  input  logic [TABLE_ENTRIES-1:0] done,
  dma_table_if.bus                 tbl
);

  localparam int PTR_W = $clog2(TABLE_ENTRIES);

  logic             access;
  logic [4:0]       offset;
  logic [PTR_W-1:0] pos;
  logic             status_hit;
  logic             done_sel;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Single-phase access, address and data in the same cycle
  assign access = hsel & hmastlock;

  // No wait states, so ready simply follows the accepted condition
  assign hready = access;

  // Low bits pick the word inside the window
  assign offset = haddr[ENTRY_STRIDE_LOG2-1:0];

  // Entry index sits right above the window
  assign pos = haddr[ENTRY_STRIDE_LOG2 +: PTR_W];

  assign status_hit = (offset == REG_STATUS);

  // Done flag of the addressed entry
  assign done_sel = done[pos];

  // One-hot field select, unknown offsets select nothing
  assign tbl.wr_select[FIELD_LADDR] = (offset == REG_LADDR);
  assign tbl.wr_select[FIELD_SIZE]  = (offset == REG_SIZE);
  assign tbl.wr_select[FIELD_RTILE] = (offset == REG_RTILE);
  assign tbl.wr_select[FIELD_RADDR] = (offset == REG_RADDR);
  assign tbl.wr_select[FIELD_DIR]   = (offset == REG_DIR);

  ////////////////////////////////////////////////////////////////////////////
  // Table commands
  ////////////////////////////////////////////////////////////////////////////

  // Field write
  assign tbl.wr_en   = access & hwrite & ~status_hit;
  assign tbl.wr_pos  = pos;
  assign tbl.wr_data = hwdata;

  // Status write sets valid
  // Status read of a done entry clears it
  assign tbl.valid_en  = access & status_hit & (hwrite | done_sel);
  assign tbl.valid_set = hwrite;
  assign tbl.valid_pos = pos;

  // Read data, only the status word carries anything
  always_comb begin
    hrdata = '0;
    if (status_hit) begin
      hrdata[0] = done_sel;
    end
  end

endmodule

/* dma_request_entry.sv */
`timescale 1ns/1ps

module dma_request_entry import dma_pkg::*; #(
  parameter int INDEX = 0
) (
  input  logic       clk,
  input  logic       rst,
  dma_table_if.entry tbl,
  dma_entry_if.entry ent,
  output logic       done
);

  logic      wr_hit;
  logic      valid_hit;
  logic      valid;

  // Descriptor registers
  bus_addr_t laddr;
  dma_size_t size;
  dma_tile_t rtile;
  bus_addr_t raddr;
  logic      dir;

  // Commands addressed to this slot
  assign wr_hit    = tbl.wr_en & (int'(tbl.wr_pos) == INDEX);
  assign valid_hit = tbl.valid_en & (int'(tbl.valid_pos) == INDEX);

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor fields
  ////////////////////////////////////////////////////////////////////////////

  // Payload only, contents are meaningless until software marks the slot valid
  always_ff @(posedge clk) begin
    if (wr_hit) begin
      if (tbl.wr_select[FIELD_LADDR]) laddr <= tbl.wr_data;
      if (tbl.wr_select[FIELD_SIZE])  size  <= tbl.wr_data[DMA_SIZE_WIDTH-1:0];
      if (tbl.wr_select[FIELD_RTILE]) rtile <= tbl.wr_data[DMA_TILE_WIDTH-1:0];
      if (tbl.wr_select[FIELD_RADDR]) raddr <= tbl.wr_data;
      if (tbl.wr_select[FIELD_DIR])   dir   <= tbl.wr_data[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and done flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      done  <= 1'b0;
    end else begin
      // Completion only counts for a live descriptor
      if (ent.complete && valid) begin
        done <= 1'b1;
      end
      if (valid_hit) begin
        if (tbl.valid_set) begin
          valid <= 1'b1;
        end else begin
          // Freed by a status read that saw done
          valid <= 1'b0;
          done  <= 1'b0;
        end
      end
    end
  end

  // Scheduler view
  assign ent.pending = valid & ~done;
  assign ent.laddr   = laddr;
  assign ent.size    = size;
  assign ent.rtile   = rtile;
  assign ent.raddr   = raddr;
  assign ent.dir     = dir;

endmodule

/* dma_request_scheduler.sv */
`timescale 1ns/1ps

module dma_request_scheduler import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic       clk,
  input  logic       rst,
  dma_entry_if.sched ent [TABLE_ENTRIES],
  output logic       req_valid,
  output bus_addr_t  req_laddr,
  output dma_size_t  req_size,
  output dma_tile_t  req_rtile,
  output bus_addr_t  req_raddr,
  output logic       req_dir,
  input  logic       req_done
);

  localparam int PTR_W = $clog2(TABLE_ENTRIES);

  sched_state_t             state;
  // Last granted entry, also the one in flight
  logic [PTR_W-1:0]         grant;
  logic                     found;
  logic [PTR_W-1:0]         next_pos;
  logic                     complete;

  // Flattened view of the entry interfaces
  logic [TABLE_ENTRIES-1:0] pending;
  bus_addr_t                laddr_tab [TABLE_ENTRIES];
  dma_size_t                size_tab  [TABLE_ENTRIES];
  dma_tile_t                rtile_tab [TABLE_ENTRIES];
  bus_addr_t                raddr_tab [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0] dir_tab;

  // Interface arrays only take constant indices
  for (genvar i = 0; i < TABLE_ENTRIES; i++) begin : g_slot
    assign pending[i]   = ent[i].pending;
    assign laddr_tab[i] = ent[i].laddr;
    assign size_tab[i]  = ent[i].size;
    assign rtile_tab[i] = ent[i].rtile;
    assign raddr_tab[i] = ent[i].raddr;
    assign dir_tab[i]   = ent[i].dir;
    // Completion goes to the in-flight entry only
    assign ent[i].complete = complete & (grant == PTR_W'(i));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin search
  ////////////////////////////////////////////////////////////////////////////

  // Start right after the last grant, the pointer wraps by its own width
  // With a full loop the last candidate is the last grant itself
  always_comb begin
    logic [PTR_W-1:0] cand;
    found    = 1'b0;
    next_pos = grant;
    for (int k = 1; k <= TABLE_ENTRIES; k++) begin
      cand = grant + PTR_W'(k);
      if (!found && pending[cand]) begin
        found    = 1'b1;
        next_pos = cand;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SCHED_IDLE;
      // Search starts at entry 0 after reset
      grant <= PTR_W'(TABLE_ENTRIES - 1);
    end else begin
      case (state)
        SCHED_IDLE: begin
          if (found) begin
            grant <= next_pos;
            state <= SCHED_ISSUE;
          end
        end
        // Request pulse lasts exactly one cycle
        SCHED_ISSUE: state <= SCHED_WAIT;
        SCHED_WAIT: begin
          if (req_done) begin
            state <= SCHED_IDLE;
          end
        end
        default: state <= SCHED_IDLE;
      endcase
    end
  end

  // Winner's fields captured with the grant, held steady through the pulse
  always_ff @(posedge clk) begin
    if (state == SCHED_IDLE && found) begin
      req_laddr <= laddr_tab[next_pos];
      req_size  <= size_tab[next_pos];
      req_rtile <= rtile_tab[next_pos];
      req_raddr <= raddr_tab[next_pos];
      req_dir   <= dir_tab[next_pos];
    end
  end

  assign req_valid = (state == SCHED_ISSUE);

  // req_done outside SCHED_WAIT is dropped
  assign complete = (state == SCHED_WAIT) & req_done;

endmodule

/* dma_ctrl.sv */
`timescale 1ns/1ps

module dma_ctrl import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic      clk,
  input  logic      rst,

  // Bus slave port
  input  logic      hsel,
  input  bus_addr_t haddr,
  input  bus_data_t hwdata,
  input  logic      hwrite,
  input  logic      hmastlock,
  output bus_data_t hrdata,
  output logic      hready,

  // Request port toward the network side
  output logic      req_valid,
  output bus_addr_t req_laddr,
  output dma_size_t req_size,
  output dma_tile_t req_rtile,
  output bus_addr_t req_raddr,
  output logic      req_dir,
  input  logic      req_done
);

  // Done flags of all entries, read back through the status word
  logic [TABLE_ENTRIES-1:0] done;

  ////////////////////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////////////////////

  dma_table_if #(.TABLE_ENTRIES(TABLE_ENTRIES)) tbl ();

  dma_entry_if ent [TABLE_ENTRIES] ();

  // Bus decode
  dma_bus_interface #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) u_bus (
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hmastlock (hmastlock),
    .hrdata    (hrdata),
    .hready    (hready),
    .done      (done),
    .tbl       (tbl.bus)
  );

  // Descriptor table
  for (genvar i = 0; i < TABLE_ENTRIES; i++) begin : g_entry
    dma_request_entry #(
      .INDEX(i)
    ) u_entry (
      .clk  (clk),
      .rst  (rst),
      .tbl  (tbl.entry),
      .ent  (ent[i].entry),
      .done (done[i])
    );
  end

  // Request issue
  dma_request_scheduler #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) u_sched (
    .clk       (clk),
    .rst       (rst),
    .ent       (ent),
    .req_valid (req_valid),
    .req_laddr (req_laddr),
    .req_size  (req_size),
    .req_rtile (req_rtile),
    .req_raddr (req_raddr),
    .req_dir   (req_dir),
    .req_done  (req_done)
  );

endmodule

/* dma_ctrl_properties.sv */
`timescale 1ns/1ps

module dma_ctrl_properties (
  input logic clk,
  input logic rst,
  input logic hsel,
  input logic hmastlock,
  input logic hready,
  input logic req_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // Port behaviour
  ////////////////////////////////////////////////////////////////////////////

  // No wait states, ready is the accept condition itself
  a_hready: assert property (@(posedge clk) hready == (hsel & hmastlock))
    else $error("hready differs from hsel and hmastlock");

  // Request is a single-cycle pulse
  a_pulse: assert property (@(posedge clk) disable iff (rst) req_valid |=> !req_valid)
    else $error("req_valid high in two consecutive cycles");

  // Scheduler held idle through reset
  a_reset: assert property (@(posedge clk) rst |=> !req_valid)
    else $error("req_valid high during reset");

endmodule

bind dma_ctrl dma_ctrl_properties u_properties (
  .clk       (clk),
  .rst       (rst),
  .hsel      (hsel),
  .hmastlock (hmastlock),
  .hready    (hready),
  .req_valid (req_valid)
);

/* dma_ctrl_tb.sv */
`timescale 1ns/1ps

module dma_ctrl_tb import dma_pkg::*; ();

  localparam int TABLE_ENTRIES = 4;
  localparam int NUM_TESTS = 6;
  localparam int TIMEOUT_CYCLES = 200;

  // Test kinds
  localparam int K_RESET  = 0;
  localparam int K_SINGLE = 1;
  localparam int K_ROUND  = 2;
  localparam int K_IGNORE = 3;

  logic      clk;
  logic      rst;
  logic      hsel;
  bus_addr_t haddr;
  bus_data_t hwdata;
  logic      hwrite;
  logic      hmastlock;
  bus_data_t hrdata;
  logic      hready;
  logic      req_valid;
  bus_addr_t req_laddr;
  dma_size_t req_size;
  dma_tile_t req_rtile;
  bus_addr_t req_raddr;
  logic      req_dir;
  logic      req_done;

  integer seed = 32'h3fdf5a06;

  // Stimulus table, marking order doubles as the set of entries used
  string     test_name [NUM_TESTS];
  int        test_kind [NUM_TESTS];
  int        test_cnt  [NUM_TESTS];
  int        test_mark [NUM_TESTS][4];
  dma_size_t test_size [NUM_TESTS];
  logic      test_dir  [NUM_TESTS];

  // Reference copy of what software wrote into each entry
  bus_addr_t exp_laddr [TABLE_ENTRIES];
  dma_size_t exp_size  [TABLE_ENTRIES];
  dma_tile_t exp_rtile [TABLE_ENTRIES];
  bus_addr_t exp_raddr [TABLE_ENTRIES];
  logic      exp_dir   [TABLE_ENTRIES];
  int        exp_order [4];

  // Requests seen by the network responder
  bus_addr_t got_laddr [$];
  dma_size_t got_size  [$];
  dma_tile_t got_rtile [$];
  bus_addr_t got_raddr [$];
  logic      got_dir   [$];
  int        issue_cnt = 0;
  int        done_cnt = 0;
  int        resp_delay;

  int        cur_test;
  int        test_errors;
  int        total_errors = 0;
  int        passed = 0;
  int        failed = 0;

  dma_ctrl #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hmastlock (hmastlock),
    .hrdata    (hrdata),
    .hready    (hready),
    .req_valid (req_valid),
    .req_laddr (req_laddr),
    .req_size  (req_size),
    .req_rtile (req_rtile),
    .req_raddr (req_raddr),
    .req_dir   (req_dir),
    .req_done  (req_done)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Network responder
  ////////////////////////////////////////////////////////////////////////////

  // Records each pulse, answers after 1 to 8 cycles
  always begin
    @(negedge clk);
    if (req_valid === 1'b1) begin
      got_laddr.push_back(req_laddr);
      got_size.push_back(req_size);
      got_rtile.push_back(req_rtile);
      got_raddr.push_back(req_raddr);
      got_dir.push_back(req_dir);
      issue_cnt++;
      resp_delay = int'({$random(seed)} % 32'd8) + 1;
      repeat (resp_delay) @(negedge clk);
      req_done = 1'b1;
      @(negedge clk);
      req_done = 1'b0;
      done_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic bus_addr_t reg_addr(input int idx, input logic [4:0] off);
    return (bus_addr_t'(idx) << ENTRY_STRIDE_LOG2) | bus_addr_t'(off);
  endfunction

  // One access per falling edge, read data sampled once settled
  task automatic bus_access(input logic sel, input logic lock, input logic wr,
                            input bus_addr_t addr, input bus_data_t data,
                            output bus_data_t rdata);
    @(negedge clk);
    hsel      = sel;
    hmastlock = lock;
    hwrite    = wr;
    haddr     = addr;
    hwdata    = data;
    #1;
    rdata = hrdata;
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    bus_data_t rd;
    bus_access(1'b1, 1'b1, 1'b1, addr, data, rd);
  endtask

  task automatic bus_idle();
    @(negedge clk);
    hsel      = 1'b0;
    hmastlock = 1'b0;
    hwrite    = 1'b0;
    haddr     = '0;
    hwdata    = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h",
               test_name[cur_test], what, exp, act);
      test_errors++;
    end
  endtask

  task automatic read_status(input int idx, input logic [31:0] exp, input string what);
    bus_data_t rd;
    bus_access(1'b1, 1'b1, 1'b0, reg_addr(idx, REG_STATUS), '0, rd);
    check_value($sformatf("%s, entry %0d", what, idx), exp, rd);
  endtask

  // Counter 0 counts request pulses, counter 1 counts completions
  task automatic wait_count(input int which, input int target, input string what);
    int waited;
    waited = 0;
    while (((which == 0) ? issue_cnt : done_cnt) < target && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (((which == 0) ? issue_cnt : done_cnt) < target) begin
      $display("Timeout in test %s: %s did not arrive within %0d cycles",
               test_name[cur_test], what, TIMEOUT_CYCLES);
      test_errors++;
    end
  endtask

  task automatic check_request(input int k, input int pos, input int idx);
    if (pos < issue_cnt) begin
      check_value($sformatf("request %0d laddr", k), exp_laddr[idx], got_laddr[pos]);
      check_value($sformatf("request %0d size", k), 32'(exp_size[idx]), 32'(got_size[pos]));
      check_value($sformatf("request %0d rtile", k), 32'(exp_rtile[idx]),
                  32'(got_rtile[pos]));
      check_value($sformatf("request %0d raddr", k), exp_raddr[idx], got_raddr[pos]);
      check_value($sformatf("request %0d dir", k), 32'(exp_dir[idx]), 32'(got_dir[pos]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // First marked entry is granted alone, the rest wait and go round-robin
  // starting right after the last grant
  task automatic predict_order(input int t);
    bit pend [TABLE_ENTRIES];
    int cur;
    int cand;
    int pick;
    for (int i = 0; i < TABLE_ENTRIES; i++) pend[i] = 1'b0;
    for (int k = 1; k < test_cnt[t]; k++) pend[test_mark[t][k]] = 1'b1;
    exp_order[0] = test_mark[t][0];
    cur = exp_order[0];
    for (int step = 1; step < test_cnt[t]; step++) begin
      pick = -1;
      for (int k = 1; k <= TABLE_ENTRIES; k++) begin
        cand = (cur + k) % TABLE_ENTRIES;
        if (pick < 0 && pend[cand]) pick = cand;
      end
      exp_order[step] = pick;
      pend[pick] = 1'b0;
      cur = pick;
    end
  endtask

  // Fields partly random, laddr tagged by test and entry
  task automatic load_entry(input int t, input int idx);
    exp_laddr[idx] = 32'h0010_0000 | (32'(t) << 12) | (32'(idx) << 4);
    exp_size[idx]  = test_size[t] + 16'(idx);
    exp_rtile[idx] = dma_tile_t'($random(seed));
    exp_raddr[idx] = $random(seed);
    exp_dir[idx]   = test_dir[t] ^ idx[0];
    bus_write(reg_addr(idx, REG_LADDR), exp_laddr[idx]);
    bus_write(reg_addr(idx, REG_SIZE), {16'h0, exp_size[idx]});
    bus_write(reg_addr(idx, REG_RTILE), {16'h0, exp_rtile[idx]});
    bus_write(reg_addr(idx, REG_RADDR), exp_raddr[idx]);
    bus_write(reg_addr(idx, REG_DIR), {31'h0, exp_dir[idx]});
  endtask

  task automatic add_test(input int t, input string name, input int kind, input int cnt,
                          input int m0, input int m1, input int m2, input int m3,
                          input dma_size_t size, input logic dir);
    test_name[t] = name;
    test_kind[t] = kind;
    test_cnt[t]  = cnt;
    test_mark[t][0] = m0;
    test_mark[t][1] = m1;
    test_mark[t][2] = m2;
    test_mark[t][3] = m3;
    test_size[t] = size;
    test_dir[t]  = dir;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test bodies
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_reset_test();
    for (int idx = 0; idx < TABLE_ENTRIES; idx++) read_status(idx, 32'h0, "status after reset");
    bus_idle();
    repeat (20) @(negedge clk);
    check_value("requests after reset", 32'h0, issue_cnt);
  endtask

  task automatic run_request_test(input int t);
    int base_issue;
    int base_done;
    base_issue = issue_cnt;
    base_done  = done_cnt;
    for (int k = 0; k < test_cnt[t]; k++) load_entry(t, test_mark[t][k]);
    // Status writes back to back, all land while the first is in flight
    for (int k = 0; k < test_cnt[t]; k++) bus_write(reg_addr(test_mark[t][k], REG_STATUS), 1);
    if (test_cnt[t] == 1) read_status(test_mark[t][0], 32'h0, "status before done");
    bus_idle();
    predict_order(t);
    wait_count(0, base_issue + test_cnt[t], "request pulses");
    wait_count(1, base_done + test_cnt[t], "completions");
    for (int k = 0; k < test_cnt[t]; k++) check_request(k, base_issue + k, exp_order[k]);
    // First read sees done and frees, second sees the freed slot
    for (int k = 0; k < test_cnt[t]; k++) begin
      read_status(test_mark[t][k], 32'h1, "status after done");
      read_status(test_mark[t][k], 32'h0, "status after free");
    end
    bus_idle();
    repeat (20) @(negedge clk);
    check_value("request count", test_cnt[t], issue_cnt - base_issue);
  endtask

  task automatic run_ignored_test(input int t);
    int        base_issue;
    int        base_done;
    int        a;
    int        b;
    bus_data_t rd;
    base_issue = issue_cnt;
    base_done  = done_cnt;
    a = test_mark[t][0];
    b = test_mark[t][1];
    load_entry(t, a);
    bus_write(reg_addr(a, REG_STATUS), 1);
    bus_idle();
    wait_count(0, base_issue + 1, "request pulse");
    wait_count(1, base_done + 1, "completion");
    check_request(0, base_issue, a);
    // Status reads without hsel or hmastlock leave done alone
    bus_access(1'b0, 1'b1, 1'b0, reg_addr(a, REG_STATUS), '0, rd);
    bus_access(1'b1, 1'b0, 1'b0, reg_addr(a, REG_STATUS), '0, rd);
    // Field and status writes that are not accepted
    bus_access(1'b0, 1'b1, 1'b1, reg_addr(b, REG_LADDR), 32'hdead_beef, rd);
    bus_access(1'b1, 1'b0, 1'b1, reg_addr(b, REG_RADDR), 32'h0bad_cafe, rd);
    bus_access(1'b0, 1'b1, 1'b1, reg_addr(b, REG_STATUS), 32'h1, rd);
    bus_access(1'b1, 1'b0, 1'b1, reg_addr(b, REG_STATUS), 32'h1, rd);
    bus_idle();
    repeat (20) @(negedge clk);
    check_value("requests after ignored access", 32'h1, issue_cnt - base_issue);
    read_status(a, 32'h1, "status kept");
    read_status(a, 32'h0, "status after free");
    read_status(b, 32'h0, "status of untouched entry");
    // Marking b now shows its earlier descriptor survived the dropped writes
    bus_write(reg_addr(b, REG_STATUS), 1);
    bus_idle();
    wait_count(0, base_issue + 2, "request pulse");
    wait_count(1, base_done + 2, "completion");
    check_request(1, base_issue + 1, b);
    read_status(b, 32'h1, "status after done");
    read_status(b, 32'h0, "status after free");
    bus_idle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    hsel      = 1'b0;
    haddr     = '0;
    hwdata    = '0;
    hwrite    = 1'b0;
    hmastlock = 1'b0;
    req_done  = 1'b0;
    add_test(0, "reset_idle",     K_RESET,  0, 0, 0, 0, 0, 16'h0000, 1'b0);
    add_test(1, "single_entry1",  K_SINGLE, 1, 1, 0, 0, 0, 16'h0040, 1'b1);
    add_test(2, "round_robin_4",  K_ROUND,  4, 2, 0, 3, 1, 16'h0100, 1'b0);
    add_test(3, "round_robin_3",  K_ROUND,  3, 0, 3, 1, 0, 16'h0200, 1'b1);
    add_test(4, "ignored_access", K_IGNORE, 2, 3, 2, 0, 0, 16'h0008, 1'b0);
    add_test(5, "single_entry0",  K_SINGLE, 1, 0, 0, 0, 0, 16'hfff0, 1'b1);
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test    = t;
      test_errors = 0;
      case (test_kind[t])
        K_RESET:  run_reset_test();
        K_IGNORE: run_ignored_test(t);
        default:  run_request_test(t);
      endcase
      $display("test %s: %s (%0d errors)", test_name[t],
               (test_errors == 0) ? "ok" : "failed", test_errors);
      if (test_errors == 0) passed++;
      else failed++;
      total_errors += test_errors;
    end
    $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             NUM_TESTS, passed, failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
dma_pkg.sv
dma_table_if.sv
dma_entry_if.sv
dma_bus_interface.sv
dma_request_entry.sv
dma_request_scheduler.sv
dma_ctrl.sv
dma_ctrl_properties.sv
dma_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the dma_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dma_ctrl_tb \
  -f sources.f -o sim_dma_ctrl

./obj_dir/sim_dma_ctrl | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
